// File: design/eth_frame_pkg.sv
package eth_frame_pkg;

    typedef logic [47:0] mac_address_t;
    typedef logic [31:0] ipv4_address_t;
    typedef logic [15:0] word16_t;
    typedef logic [7:0]  frame_data_t;

    // Fields latched when a frame is accepted
    typedef struct packed {
        mac_address_t  mac_destination;
        mac_address_t  mac_source;
        ipv4_address_t ipv4_source;
        ipv4_address_t ipv4_destination;
        word16_t       identification;
        word16_t       flags;
        word16_t       udp_source_port;
        word16_t       udp_destination_port;
        word16_t       udp_checksum;
        word16_t       payload_size;
    } header_fields_t;

    //////////////////////////////////////////////////////////////////////
    // Fixed protocol values
    //////////////////////////////////////////////////////////////////////

    parameter word16_t     ETHERTYPE_IPV4    = 16'h0800;
    parameter frame_data_t IPV4_VERSION_IHL  = 8'h45;
    parameter frame_data_t IPV4_DSCP         = 8'h00;
    parameter frame_data_t IPV4_TTL          = 8'h80;
    parameter frame_data_t IPV4_PROTOCOL_UDP = 8'h11;

    parameter int IPV4_HEADER_BYTES = 20;
    parameter int UDP_HEADER_BYTES  = 8;

    // Smallest UDP data field that fills a 46 byte Ethernet payload
    parameter int MIN_UDP_DATA_BYTES = 18;

endpackage

// File: design/frame_stream_pkg.sv
package frame_stream_pkg;

    import eth_frame_pkg::*;

    // One byte of the outgoing stream with its framing flags
    typedef struct packed {
        logic        start;
        logic        last;
        frame_data_t data;
    } frame_byte_t;

    typedef logic [31:0] crc32_t;

    // IEEE 802.3 polynomial, bit reversed
    parameter crc32_t CRC32_POLY_REFLECTED = 32'hEDB8_8320;
    parameter crc32_t CRC32_INIT           = 32'hFFFF_FFFF;

    typedef enum logic [2:0] {
        S_IDLE,
        S_MAC,
        S_HEADER,
        S_PAYLOAD,
        S_PAD
    } sequencer_state_t;

endpackage

// File: design/ipv4_header_checksum.sv
`timescale 1ns/100ps

module ipv4_header_checksum
    import eth_frame_pkg::*;
(
    input  logic           clock,
    input  logic           reset_n,
    input  logic           start,
    input  header_fields_t captured_header,
    output word16_t        header_checksum
);

    localparam int HEADER_WORDS = IPV4_HEADER_BYTES / 2;

    logic        busy;
    logic [3:0]  word_index;
    logic [3:0]  word_select;
    word16_t     sum;
    word16_t     sum_base;
    word16_t     header_word;
    logic [16:0] raw_sum;
    word16_t     next_sum;

    // First word is added on the start edge itself
    assign word_select = start ? 4'd0 : word_index;
    assign sum_base    = start ? '0 : sum;

    always_comb begin
        case (word_select)
            4'd0:    header_word = {IPV4_VERSION_IHL, IPV4_DSCP};
            4'd1:    header_word = captured_header.payload_size
                                   + word16_t'(IPV4_HEADER_BYTES + UDP_HEADER_BYTES);
            4'd2:    header_word = captured_header.identification;
            4'd3:    header_word = captured_header.flags;
            4'd4:    header_word = {IPV4_TTL, IPV4_PROTOCOL_UDP};
            4'd6:    header_word = captured_header.ipv4_source[31:16];
            4'd7:    header_word = captured_header.ipv4_source[15:0];
            4'd8:    header_word = captured_header.ipv4_destination[31:16];
            4'd9:    header_word = captured_header.ipv4_destination[15:0];
            default: header_word = '0;   // checksum field itself
        endcase
    end

    // End-around carry
    assign raw_sum  = {1'b0, sum_base} + {1'b0, header_word};
    assign next_sum = raw_sum[15:0] + word16_t'(raw_sum[16]);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy       <= 1'b0;
            word_index <= '0;
        end else if (start) begin
            busy       <= 1'b1;
            word_index <= 4'd1;
        end else if (busy) begin
            word_index <= word_index + 1'b1;
            if (word_index == 4'(HEADER_WORDS)) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start || (busy && word_index < 4'(HEADER_WORDS))) begin
            sum <= next_sum;
        end
        if (busy && word_index == 4'(HEADER_WORDS)) begin
            header_checksum <= ~sum;
        end
    end

    start_while_busy: assert property (
        @(posedge clock) disable iff (!reset_n)
        start |-> !busy
    ) else $error("checksum restarted while a sum was in progress");

endmodule

// File: design/frame_sequencer.sv
`timescale 1ns/100ps

module frame_sequencer
    import eth_frame_pkg::*;
    import frame_stream_pkg::*;
#(
    parameter int BUFFER_ADDRESS_WIDTH = 11
) (
    input  logic                            clock,
    input  logic                            reset_n,
    input  logic                            enable,
    input  header_fields_t                  header,
    input  word16_t                         header_checksum,
    input  logic                            frame_done,
    output header_fields_t                  captured_header,
    output logic                            checksum_start,
    output logic [BUFFER_ADDRESS_WIDTH-1:0] buffer_address,
    input  frame_data_t                     buffer_data,
    output frame_byte_t                     seq_byte,
    output logic                            seq_valid,
    output logic                            ready
);

    localparam int MAC_HEADER_BYTES = 14;
    localparam int HEADER_BYTES     = MAC_HEADER_BYTES + IPV4_HEADER_BYTES + UDP_HEADER_BYTES;
    // Destination and source addresses
    localparam int MAC_LAST         = 11;
    localparam int HEADER_LAST      = HEADER_BYTES - 1;
    localparam int PAD_LAST         = HEADER_BYTES + MIN_UDP_DATA_BYTES - 1;

    sequencer_state_t state;
    word16_t          byte_count;
    logic             in_flight;
    logic             accept;
    logic             address_more;
    word16_t          ipv4_total_length;
    word16_t          udp_length;
    word16_t          payload_last;

    frame_data_t [0:HEADER_BYTES-1] header_bytes;

    assign accept = ready && enable;

    assign ipv4_total_length = captured_header.payload_size
                               + word16_t'(IPV4_HEADER_BYTES + UDP_HEADER_BYTES);
    assign udp_length        = captured_header.payload_size + word16_t'(UDP_HEADER_BYTES);
    assign payload_last      = captured_header.payload_size + word16_t'(HEADER_LAST);

    // Stop the read address on the final payload byte
    assign address_more = (32'(buffer_address) + 32'd1) < 32'(captured_header.payload_size);

    // Everything ahead of the UDP data, in wire order
    assign header_bytes = {
        captured_header.mac_destination,
        captured_header.mac_source,
        ETHERTYPE_IPV4,
        IPV4_VERSION_IHL,
        IPV4_DSCP,
        ipv4_total_length,
        captured_header.identification,
        captured_header.flags,
        IPV4_TTL,
        IPV4_PROTOCOL_UDP,
        header_checksum,
        captured_header.ipv4_source,
        captured_header.ipv4_destination,
        captured_header.udp_source_port,
        captured_header.udp_destination_port,
        udp_length,
        captured_header.udp_checksum
    };

    always_ff @(posedge clock) begin
        if (accept) begin
            captured_header <= header;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Byte sequencing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state          <= S_IDLE;
            byte_count     <= '0;
            buffer_address <= '0;
            seq_byte       <= '0;
            seq_valid      <= 1'b0;
            checksum_start <= 1'b0;
        end else begin
            seq_valid      <= 1'b0;
            seq_byte       <= '0;
            byte_count     <= byte_count + 1'b1;
            checksum_start <= accept;

            case (state)
                S_IDLE: begin
                    byte_count <= '0;
                    if (accept) begin
                        buffer_address <= '0;
                        state          <= S_MAC;
                    end
                end
                S_MAC: begin
                    seq_valid      <= 1'b1;
                    seq_byte.start <= (byte_count == '0);
                    seq_byte.data  <= header_bytes[byte_count[5:0]];
                    if (byte_count == MAC_LAST) begin
                        state <= S_HEADER;
                    end
                end
                S_HEADER: begin
                    seq_valid     <= 1'b1;
                    seq_byte.data <= header_bytes[byte_count[5:0]];
                    if (byte_count == HEADER_LAST) begin
                        // Buffer already holds address 0, fetch the next one
                        if (address_more) begin
                            buffer_address <= buffer_address + 1'b1;
                        end
                        state <= (captured_header.payload_size == '0) ? S_PAD : S_PAYLOAD;
                    end
                end
                S_PAYLOAD: begin
                    seq_valid     <= 1'b1;
                    seq_byte.data <= buffer_data;
                    if (address_more) begin
                        buffer_address <= buffer_address + 1'b1;
                    end
                    if (byte_count == payload_last) begin
                        if (captured_header.payload_size < MIN_UDP_DATA_BYTES) begin
                            state <= S_PAD;
                        end else begin
                            seq_byte.last <= 1'b1;
                            state         <= S_IDLE;
                        end
                    end
                end
                S_PAD: begin
                    seq_valid <= 1'b1;
                    if (byte_count == PAD_LAST) begin
                        seq_byte.last <= 1'b1;
                        state         <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Ready stays low until the FCS has left the CRC stage
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ready     <= 1'b0;
            in_flight <= 1'b0;
        end else if (accept) begin
            ready     <= 1'b0;
            in_flight <= 1'b1;
        end else if (frame_done || !in_flight) begin
            ready     <= 1'b1;
            in_flight <= 1'b0;
        end
    end

    seq_valid_no_gap: assert property (
        @(posedge clock) disable iff (!reset_n)
        seq_valid && !seq_byte.last |=> seq_valid
    ) else $error("seq_valid dropped before the last frame byte");

endmodule

// File: design/frame_crc32.sv
`timescale 1ns/100ps

module frame_crc32
    import eth_frame_pkg::*;
    import frame_stream_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  frame_byte_t seq_byte,
    input  logic        seq_valid,
    output frame_byte_t frame_out,
    output logic        frame_valid,
    output logic        frame_done
);

    crc32_t     crc;
    logic       fcs_active;
    logic [1:0] fcs_count;

    // Reflected CRC-32, one byte, LSB first
    function automatic crc32_t crc32_next(crc32_t crc_in, frame_data_t data);
        crc32_t c;
        c = crc_in ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC32_POLY_REFLECTED) : (c >> 1);
        end
        return c;
    endfunction

    // Shifted down a byte per FCS byte sent
    always_ff @(posedge clock) begin
        if (seq_valid) begin
            crc <= crc32_next(seq_byte.start ? CRC32_INIT : crc, seq_byte.data);
        end else if (fcs_active) begin
            crc <= crc >> 8;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            frame_out   <= '0;
            frame_valid <= 1'b0;
            frame_done  <= 1'b0;
            fcs_active  <= 1'b0;
            fcs_count   <= '0;
        end else begin
            frame_done <= 1'b0;
            if (seq_valid) begin
                frame_out      <= seq_byte;
                frame_out.last <= 1'b0;
                frame_valid    <= 1'b1;
                if (seq_byte.last) begin
                    fcs_active <= 1'b1;
                    fcs_count  <= '0;
                end
            end else if (fcs_active) begin
                frame_out.start <= 1'b0;
                frame_out.last  <= (fcs_count == 2'd3);
                frame_out.data  <= ~crc[7:0];
                frame_valid     <= 1'b1;
                fcs_count       <= fcs_count + 1'b1;
                if (fcs_count == 2'd3) begin
                    fcs_active <= 1'b0;
                    frame_done <= 1'b1;
                end
            end else begin
                frame_out   <= '0;
                frame_valid <= 1'b0;
            end
        end
    end

    no_byte_during_fcs: assert property (
        @(posedge clock) disable iff (!reset_n)
        fcs_active |-> !seq_valid
    ) else $error("sequencer byte arrived while FCS was being sent");

endmodule

// File: design/udp_frame_generator.sv
`timescale 1ns/100ps

module udp_frame_generator
    import eth_frame_pkg::*;
    import frame_stream_pkg::*;
#(
    parameter int BUFFER_ADDRESS_WIDTH = 11
) (
    input  logic                            clock,
    input  logic                            reset_n,
    input  logic                            enable,
    input  header_fields_t                  header,
    output logic [BUFFER_ADDRESS_WIDTH-1:0] buffer_address,
    input  frame_data_t                     buffer_data,
    output frame_byte_t                     frame_out,
    output logic                            frame_valid,
    output logic                            ready
);

    header_fields_t captured_header;
    logic           checksum_start;
    word16_t        header_checksum;
    frame_byte_t    seq_byte;
    logic           seq_valid;
    logic           frame_done;

    frame_sequencer #(
        .BUFFER_ADDRESS_WIDTH (BUFFER_ADDRESS_WIDTH)
    ) sequencer0 (
        .clock           (clock),
        .reset_n         (reset_n),
        .enable          (enable),
        .header          (header),
        .header_checksum (header_checksum),
        .frame_done      (frame_done),
        .captured_header (captured_header),
        .checksum_start  (checksum_start),
        .buffer_address  (buffer_address),
        .buffer_data     (buffer_data),
        .seq_byte        (seq_byte),
        .seq_valid       (seq_valid),
        .ready           (ready)
    );

    ipv4_header_checksum checksum0 (
        .clock           (clock),
        .reset_n         (reset_n),
        .start           (checksum_start),
        .captured_header (captured_header),
        .header_checksum (header_checksum)
    );

    frame_crc32 crc0 (
        .clock       (clock),
        .reset_n     (reset_n),
        .seq_byte    (seq_byte),
        .seq_valid   (seq_valid),
        .frame_out   (frame_out),
        .frame_valid (frame_valid),
        .frame_done  (frame_done)
    );

endmodule

// File: bench/udp_frame_generator_tb.sv
`timescale 1ns/100ps

module udp_frame_generator_tb
    import eth_frame_pkg::*;
    import frame_stream_pkg::*;
();

    localparam int ADDRESS_WIDTH = 11;
    localparam int CLOCK_PERIOD  = 8;
    localparam int WAIT_LIMIT    = 2000;

    logic                     clock = 1'b0;
    logic                     reset_n;
    logic                     enable;
    header_fields_t           header;
    logic [ADDRESS_WIDTH-1:0] buffer_address;
    logic [ADDRESS_WIDTH-1:0] read_address = '0;
    frame_data_t              buffer_data;
    frame_byte_t              frame_out;
    logic                     frame_valid;
    logic                     ready;

    // Reference model state
    logic        exp_ready;
    logic        exp_valid;
    frame_byte_t exp_out;
    logic        model_active;
    int          model_index;
    word16_t     model_size;
    logic [31:0] address_limit;
    frame_data_t expected_frame[$];

    logic [31:0] lfsr_state = 32'he5ce_a745;
    int          error_count;
    int          timeout_count;

    udp_frame_generator #(
        .BUFFER_ADDRESS_WIDTH (ADDRESS_WIDTH)
    ) dut0 (
        .clock          (clock),
        .reset_n        (reset_n),
        .enable         (enable),
        .header         (header),
        .buffer_address (buffer_address),
        .buffer_data    (buffer_data),
        .frame_out      (frame_out),
        .frame_valid    (frame_valid),
        .ready          (ready)
    );

    initial begin
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    //////////////////////////////////////////////////////////////////////
    // Payload buffer and random source
    //////////////////////////////////////////////////////////////////////

    function automatic frame_data_t buffer_pattern(logic [ADDRESS_WIDTH-1:0] address);
        logic [31:0] product;
        product = 32'(address) * 32'd7 + 32'd3;
        return product[7:0];
    endfunction

    // Synchronous read with data presented on the falling edge
    always @(posedge clock) begin
        read_address <= buffer_address;
    end

    always @(negedge clock) begin
        buffer_data <= buffer_pattern(read_address);
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_step();
        logic feedback;
        feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [63:0] random_bits(int count);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[62:0], lfsr_step()};
        end
        return value;
    endfunction

    task automatic randomize_header(input word16_t size);
        header.mac_destination      = mac_address_t'(random_bits(48));
        header.mac_source           = mac_address_t'(random_bits(48));
        header.ipv4_source          = ipv4_address_t'(random_bits(32));
        header.ipv4_destination     = ipv4_address_t'(random_bits(32));
        header.identification       = word16_t'(random_bits(16));
        header.flags                = word16_t'(random_bits(16));
        header.udp_source_port      = word16_t'(random_bits(16));
        header.udp_destination_port = word16_t'(random_bits(16));
        header.udp_checksum         = word16_t'(random_bits(16));
        header.payload_size         = size;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    task automatic push_field(input logic [47:0] value, input int count);
        for (int i = count - 1; i >= 0; i--) begin
            expected_frame.push_back(value[8*i +: 8]);
        end
    endtask

    task automatic build_expected(input header_fields_t h);
        logic [31:0] sum;
        crc32_t      crc;
        logic        feedback;
        int          data_bytes;
        expected_frame.delete();
        push_field(h.mac_destination, 6);
        push_field(h.mac_source, 6);
        push_field(48'h0800, 2);
        push_field(48'h4500, 2);
        push_field(h.payload_size + 16'd28, 2);
        push_field(h.identification, 2);
        push_field(h.flags, 2);
        push_field(48'h8011, 2);
        push_field(48'h0000, 2);
        push_field(h.ipv4_source, 4);
        push_field(h.ipv4_destination, 4);
        push_field(h.udp_source_port, 2);
        push_field(h.udp_destination_port, 2);
        push_field(h.payload_size + 16'd8, 2);
        push_field(h.udp_checksum, 2);
        // IPv4 header spans bytes 14 to 33 with its checksum at 24
        sum = '0;
        for (int i = 14; i < 34; i += 2) begin
            sum = sum + {16'h0, expected_frame[i], expected_frame[i+1]};
        end
        sum = sum[15:0] + sum[31:16];
        sum = sum[15:0] + sum[31:16];
        expected_frame[24] = ~sum[15:8];
        expected_frame[25] = ~sum[7:0];
        data_bytes = (h.payload_size < 18) ? 18 : int'(h.payload_size);
        for (int i = 0; i < data_bytes; i++) begin
            if (i < h.payload_size) begin
                expected_frame.push_back(buffer_pattern(ADDRESS_WIDTH'(i)));
            end else begin
                expected_frame.push_back(8'h00);
            end
        end
        crc = 32'hFFFF_FFFF;
        foreach (expected_frame[i]) begin
            for (int b = 0; b < 8; b++) begin
                feedback = crc[0] ^ expected_frame[i][b];
                crc      = crc >> 1;
                if (feedback) begin
                    crc = crc ^ 32'hEDB8_8320;
                end
            end
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            expected_frame.push_back(crc[8*i +: 8]);
        end
    endtask

    // Cycle model of the output stream and ready
    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            exp_ready    <= 1'b0;
            exp_valid    <= 1'b0;
            exp_out      <= '0;
            model_active <= 1'b0;
            model_index  <= 0;
            model_size   <= '0;
        end else if (exp_ready && enable) begin
            build_expected(header);
            exp_ready    <= 1'b0;
            model_active <= 1'b1;
            model_index  <= -1;
            model_size   <= header.payload_size;
        end else if (model_active) begin
            model_index <= model_index + 1;
            exp_valid   <= 1'b0;
            if (model_index == int'(expected_frame.size())) begin
                model_active <= 1'b0;
                exp_ready    <= 1'b1;
            end else if (model_index >= 0) begin
                exp_valid     <= 1'b1;
                exp_out.start <= (model_index == 0);
                exp_out.last  <= (model_index == int'(expected_frame.size()) - 1);
                exp_out.data  <= expected_frame[model_index];
            end
        end else begin
            exp_ready <= 1'b1;
        end
    end

    // Reads stay inside the payload of the current frame
    assign address_limit = (model_size == '0) ? 32'd1 : 32'(model_size);

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        $display("CHECK FAILED at %0t: %s expected %0h actual %0h",
                 $time, name, expected, actual);
    endtask

    reset_check: assert property (@(posedge clock) !reset_n |-> !frame_valid && !ready)
        else report_mismatch("{frame_valid, ready}", 0, $sampled({frame_valid, ready}));

    ready_check: assert property (
        @(posedge clock) disable iff (!reset_n) ready == exp_ready
    ) else report_mismatch("ready", $sampled(exp_ready), $sampled(ready));

    valid_check: assert property (
        @(posedge clock) disable iff (!reset_n) frame_valid == exp_valid
    ) else report_mismatch("frame_valid", $sampled(exp_valid), $sampled(frame_valid));

    data_check: assert property (
        @(posedge clock) disable iff (!reset_n) frame_valid |-> frame_out.data == exp_out.data
    ) else report_mismatch("frame_out.data", $sampled(exp_out.data), $sampled(frame_out.data));

    start_check: assert property (
        @(posedge clock) disable iff (!reset_n) frame_valid |-> frame_out.start == exp_out.start
    ) else report_mismatch("frame_out.start", $sampled(exp_out.start),
                           $sampled(frame_out.start));

    last_check: assert property (
        @(posedge clock) disable iff (!reset_n) frame_valid |-> frame_out.last == exp_out.last
    ) else report_mismatch("frame_out.last", $sampled(exp_out.last), $sampled(frame_out.last));

    address_check: assert property (
        @(posedge clock) disable iff (!reset_n) 32'(buffer_address) < address_limit
    ) else begin
        error_count++;
        $display("CHECK FAILED at %0t: buffer_address expected below %0h actual %0h",
                 $time, $sampled(address_limit), $sampled(buffer_address));
    end

    task automatic finish_run();
        $display("Errors: %0d check failures, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    task automatic check_timeout(input int cycles, input string what);
        if (cycles >= WAIT_LIMIT) begin
            timeout_count++;
            $display("Timeout at %0t: %s", $time, what);
            finish_run();
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!ready && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        check_timeout(cycles, "ready did not rise");
    endtask

    // Hold keeps enable high for the whole frame
    task automatic send_frame(input word16_t size, input logic hold);
        int cycles;
        wait_ready();
        randomize_header(size);
        enable = 1'b1;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (ready && cycles < WAIT_LIMIT);
        check_timeout(cycles, "frame was not accepted");
        if (!hold) begin
            enable = 1'b0;
            randomize_header(word16_t'(random_bits(7)));
        end
        cycles = 0;
        while (!(frame_valid && frame_out.last) && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        check_timeout(cycles, "final FCS byte did not appear");
        enable = 1'b0;
    endtask

    initial begin
        word16_t sizes[$];
        reset_n       = 1'b0;
        enable        = 1'b0;
        header        = '0;
        buffer_data   = '0;
        error_count   = 0;
        timeout_count = 0;
        sizes = '{16'd0, 16'd1, 16'd17, 16'd18, 16'd40};
        for (int i = 0; i < 6; i++) begin
            sizes.push_back(word16_t'(random_bits(7)));
        end
        repeat (8) @(negedge clock);
        reset_n = 1'b1;
        foreach (sizes[i]) begin
            send_frame(sizes[i], i[0]);
        end
        wait_ready();
        @(negedge clock);
        finish_run();
    end

endmodule

// File: compile.f
design/eth_frame_pkg.sv
design/frame_stream_pkg.sv
design/ipv4_header_checksum.sv
design/frame_sequencer.sv
design/frame_crc32.sv
design/udp_frame_generator.sv
bench/udp_frame_generator_tb.sv
